/* source/conv_macros.svh */
`ifndef CONV_MACROS_SVH
`define CONV_MACROS_SVH

//////////////////////////////////////////////////
// array geometry
//////////////////////////////////////////////////

`define CONV_COLS 4    // pixels per beat, one per column
`define CONV_CHANS 4   // output channels, one lane each

//////////////////////////////////////////////////
// datapath widths
//////////////////////////////////////////////////

// pixel, weight and bias share one width
`define PIX_W 8

// signed accumulator, headroom over 16 bit products
`define ACC_W 24

// unsigned scale tail
`define TAIL_W 16

// scale rank, right shift 0..31
`define RANK_W 5

// (acc + bias) x tail, signed
`define PROD_W 41

// quantized result
`define Q_W 8

`endif

/* source/conv_pkg.sv */
`include "conv_macros.svh"

package conv_pkg;

    //////////////////////////////////////////////////
    // input beat
    //////////////////////////////////////////////////

    // one row of signed pixels, column 0 in the low byte
    typedef logic [`CONV_COLS-1:0][`PIX_W-1:0] pixel_row_t;

    // signed weight per output channel
    typedef logic [`CONV_CHANS-1:0][`PIX_W-1:0] weight_set_t;

    typedef struct packed {
        pixel_row_t  pixels;
        weight_set_t weights;
        logic        last;      // closes the tile
    } beat_t;

    //////////////////////////////////////////////////
    // per channel post-processing parameters
    //////////////////////////////////////////////////

    typedef struct packed {
        logic [`PIX_W-1:0]  bias;   // signed
        logic [`TAIL_W-1:0] tail;   // unsigned multiplier
        logic [`RANK_W-1:0] rank;   // right shift after rounding
    } chan_param_t;

    // whole tile, channel 0 in the low slice
    typedef chan_param_t [`CONV_CHANS-1:0] tile_param_t;

    //////////////////////////////////////////////////
    // results
    //////////////////////////////////////////////////

    // one channel's quantized outputs across the columns
    typedef logic [`CONV_COLS-1:0][`Q_W-1:0] q_row_t;

    // all lanes together, as the drain captures them
    typedef q_row_t [`CONV_CHANS-1:0] q_set_t;

endpackage

/* source/beat_feeder.sv */
`include "conv_macros.svh"

module beat_feeder import conv_pkg::*; (
    input  logic        clk,
    input  logic        reset,

    input  logic        pix_valid,
    input  beat_t       beat_in,
    input  logic        param_load,
    input  tile_param_t params_in,

    output beat_t       beat,
    output logic        beat_valid,
    output tile_param_t params
);

    //////////////////////////////////////////////////
    // beat register
    //////////////////////////////////////////////////

    // single feeding point shared by all lanes
    // the strobe is control, the beat itself is payload

    always_ff @(posedge clk) begin
        if (reset) begin
            beat_valid <= 1'b0;
        end else begin
            beat_valid <= pix_valid;    // one taken beat per strobe
        end
    end

    always_ff @(posedge clk) begin
        if (pix_valid) begin
            beat <= beat_in;            // held while idle
        end
    end

    //////////////////////////////////////////////////
    // tile parameters
    //////////////////////////////////////////////////

    // held from one load to the next
    // lanes take their own copy on the last beat, so a load
    // right after a last beat leaves that tile untouched

    always_ff @(posedge clk) begin
        if (reset) begin
            params <= '0;
        end else if (param_load) begin
            params <= params_in;
        end
    end

endmodule

/* source/channel_lane.sv */
`include "conv_macros.svh"

module channel_lane import conv_pkg::*; (
    input  logic                     clk,
    input  logic                     reset,

    input  beat_t                    beat,
    input  logic                     beat_valid,
    input  logic signed [`PIX_W-1:0] weight,    // this lane's weight
    input  chan_param_t              param,

    output q_row_t                   q_row,
    output logic                     lane_done
);

    logic signed [`ACC_W-1:0]  acc      [`CONV_COLS];
    logic signed [`ACC_W-1:0]  acc_next [`CONV_COLS];
    logic                      prev_last;     // next beat restarts the sum
    logic                      fin_valid;     // acc holds a finished tile
    chan_param_t               fin_param;     // params as of the last beat
    logic                      s1_valid;
    logic signed [`PROD_W-1:0] s1_prod  [`CONV_COLS];
    logic [`RANK_W-1:0]        s1_rank;

    // (sum + bias) x tail, tail is unsigned so zero extend it
    function automatic logic signed [`PROD_W-1:0] scale_sum(
        input logic signed [`ACC_W-1:0] sum,
        input logic [`PIX_W-1:0]        bias,
        input logic [`TAIL_W-1:0]       tail
    );
        logic signed [`PROD_W-1:0] biased;
        logic signed [`PROD_W-1:0] tail_ext;
        biased = sum;
        biased = biased + $signed(bias);
        tail_ext = {{(`PROD_W-`TAIL_W){1'b0}}, tail};
        scale_sum = biased * tail_ext;
    endfunction

    // round half up, arithmetic shift, clamp to signed Q_W
    function automatic logic [`Q_W-1:0] quantize(
        input logic signed [`PROD_W-1:0] prod,
        input logic [`RANK_W-1:0]        rank
    );
        logic signed [`PROD_W-1:0] half;
        logic signed [`PROD_W-1:0] shifted;
        logic [`PROD_W-`Q_W:0]     top;
        half = '0;
        if (rank != '0) begin
            half[rank - 1'b1] = 1'b1;     // 2^(rank-1)
        end
        shifted = (prod + half) >>> rank;
        top = shifted[`PROD_W-1:`Q_W-1];
        if (&top || ~|top) begin
            quantize = shifted[`Q_W-1:0];           // already in range
        end else if (shifted[`PROD_W-1]) begin
            quantize = {1'b1, {(`Q_W-1){1'b0}}};    // -128
        end else begin
            quantize = {1'b0, {(`Q_W-1){1'b1}}};    // 127
        end
    endfunction

    //////////////////////////////////////////////////
    // multiply accumulate
    //////////////////////////////////////////////////

    always_comb begin
        logic signed [2*`PIX_W-1:0] mac;
        for (int c = 0; c < `CONV_COLS; c++) begin
            mac = $signed(beat.pixels[c]) * weight;
            acc_next[c] = prev_last ? mac : acc[c] + mac;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int c = 0; c < `CONV_COLS; c++) begin
                acc[c] <= '0;
            end
            prev_last <= 1'b0;
            fin_valid <= 1'b0;
            s1_valid  <= 1'b0;
            lane_done <= 1'b0;
        end else begin
            fin_valid <= beat_valid & beat.last;   // T+1
            s1_valid  <= fin_valid;                // T+2
            lane_done <= s1_valid;                 // T+3, all lanes together
            if (beat_valid) begin
                acc       <= acc_next;
                prev_last <= beat.last;
            end
        end
    end

    //////////////////////////////////////////////////
    // bias, scale and quantize
    //////////////////////////////////////////////////

    // acc may already restart for the next tile at T+2,
    // stage one reads it before that update lands
    always_ff @(posedge clk) begin
        if (beat_valid && beat.last) begin
            fin_param <= param;
        end
        if (fin_valid) begin
            for (int c = 0; c < `CONV_COLS; c++) begin
                s1_prod[c] <= scale_sum(acc[c], fin_param.bias, fin_param.tail);
            end
            s1_rank <= fin_param.rank;
        end
        if (s1_valid) begin
            for (int c = 0; c < `CONV_COLS; c++) begin
                q_row[c] <= quantize(s1_prod[c], s1_rank);
            end
        end
    end

endmodule

/* source/result_drain.sv */
`include "conv_macros.svh"

module result_drain import conv_pkg::*; (
    input  logic       clk,
    input  logic       reset,

    input  q_set_t     lane_rows,
    input  logic       lane_done,    // all lanes finish together

    output logic       out_valid,
    output logic [1:0] out_chan,
    output q_row_t     out_row
);

    q_set_t held_rows;
    logic   last_chan;

    assign last_chan = (out_chan == 2'(`CONV_CHANS - 1));

    //////////////////////////////////////////////////
    // channel walk
    //////////////////////////////////////////////////

    // like the output row index of the array, one channel per cycle
    // a new lane_done restarts the walk from channel 0

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            out_chan  <= '0;
        end else if (lane_done) begin
            out_valid <= 1'b1;          // channel 0 at T+4
            out_chan  <= '0;
        end else if (out_valid) begin
            if (last_chan) begin
                out_valid <= 1'b0;
                out_chan  <= '0;
            end else begin
                out_chan <= out_chan + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // result hold
    //////////////////////////////////////////////////

    // lanes may move on to the next tile while we present
    always_ff @(posedge clk) begin
        if (lane_done) begin
            held_rows <= lane_rows;
        end
    end

    assign out_row = held_rows[out_chan];

endmodule

/* source/conv_core.sv */
`include "conv_macros.svh"

module conv_core import conv_pkg::*; (
    input  logic        clk,
    input  logic        reset,

    input  logic        pix_valid,
    input  beat_t       beat_in,
    input  logic        param_load,
    input  tile_param_t params_in,

    output logic        out_valid,
    output logic [1:0]  out_chan,
    output q_row_t      out_row
);

    beat_t                   beat;
    logic                    beat_valid;
    tile_param_t             params;
    q_set_t                  lane_rows;
    logic [`CONV_CHANS-1:0]  lane_done;

    beat_feeder feeder_i (
        .clk        (clk),
        .reset      (reset),
        .pix_valid  (pix_valid),
        .beat_in    (beat_in),
        .param_load (param_load),
        .params_in  (params_in),
        .beat       (beat),
        .beat_valid (beat_valid),
        .params     (params)
    );

    //////////////////////////////////////////////////
    // one lane per output channel
    //////////////////////////////////////////////////

    for (genvar g = 0; g < `CONV_CHANS; g++) begin : lane
        channel_lane lane_i (
            .clk        (clk),
            .reset      (reset),
            .beat       (beat),
            .beat_valid (beat_valid),
            .weight     (beat.weights[g]),   // weight column of this channel
            .param      (params[g]),
            .q_row      (lane_rows[g]),
            .lane_done  (lane_done[g])
        );
    end

    // lanes run in lockstep, lane 0 stands for all of them
    result_drain drain_i (
        .clk       (clk),
        .reset     (reset),
        .lane_rows (lane_rows),
        .lane_done (lane_done[0]),
        .out_valid (out_valid),
        .out_chan  (out_chan),
        .out_row   (out_row)
    );

endmodule

/* bench/conv_tests.svh */
//////////////////////////////////////////////////
// stimulus and checking helpers
//////////////////////////////////////////////////

task automatic drive_cycle(input logic valid, input beat_t b,
                           input logic load, input tile_param_t p);
    @(posedge clk);
    pix_valid  <= valid;
    beat_in    <= b;
    param_load <= load;
    params_in  <= p;
    if (valid && b.last) begin
        last_take_time = $time + CLK_PERIOD;    // taken on the next edge
    end
endtask

task automatic idle_cycles(input int n);
    repeat (n) drive_cycle(1'b0, '0, 1'b0, '0);
endtask

task automatic load_params(input tile_param_t p);
    drive_cycle(1'b0, '0, 1'b1, p);
endtask

function automatic chan_param_t chan_param(input int bias, input int tail, input int rank);
    chan_param_t cp;
    cp.bias = 8'(bias);
    cp.tail = 16'(tail);
    cp.rank = 5'(rank);
    return cp;
endfunction

function automatic void add_beat(input int px[`CONV_COLS], input int wt[`CONV_CHANS]);
    beat_t b;
    b = '0;
    foreach (px[c]) b.pixels[c] = 8'(px[c]);
    foreach (wt[ch]) b.weights[ch] = 8'(wt[ch]);
    tile_q.push_back(b);
endfunction

function automatic void add_random_beat();
    beat_t b;
    b = '0;
    b.pixels  = $random(seed);
    b.weights = $random(seed);
    tile_q.push_back(b);
endfunction

// first beat may carry the parameter load
task automatic send_tile(input int gap_max, input logic load, input tile_param_t p);
    int gap;
    tile_q[tile_q.size() - 1].last = 1'b1;
    foreach (tile_q[i]) begin
        gap = (gap_max > 0) ? int'($unsigned($random(seed)) % (gap_max + 1)) : 0;
        idle_cycles(gap);
        drive_cycle(1'b1, tile_q[i], load && (i == 0), p);
    end
endtask

function automatic void expect_tile(input tile_param_t p);
    q_set_t res;
    res = model_tile(p);
    for (int ch = 0; ch < `CONV_CHANS; ch++) begin
        exp_rows.push_back(res[ch]);
    end
endfunction

task automatic check_outputs(input bit check_latency);
    int waited;
    waited = 0;
    while (got_rows.size() < exp_rows.size() && waited < WAIT_LIMIT) begin
        @(negedge clk);
        waited++;
    end
    if (got_rows.size() < exp_rows.size()) begin
        $display("timeout: only %0d of %0d output rows arrived", got_rows.size(),
                 exp_rows.size());
        test_errors++;
    end else begin
        // walk ends right after the last channel
        @(negedge clk);
        assert (!out_valid) else begin
            $display("** Error: out_valid expected 0x0, got 0x%h", out_valid);
            test_errors++;
        end
        foreach (exp_rows[i]) begin
            assert (got_rows[i] == exp_rows[i]) else begin
                $display("** Error: out_row (row %0d) expected 0x%h, got 0x%h", i,
                         exp_rows[i], got_rows[i]);
                test_errors++;
            end
            assert (got_chans[i] == 2'(i % `CONV_CHANS)) else begin
                $display("** Error: out_chan (row %0d) expected 0x%h, got 0x%h", i,
                         2'(i % `CONV_CHANS), got_chans[i]);
                test_errors++;
            end
        end
        // first row 4 edges after the last beat, sampled half a period later
        if (check_latency) begin
            assert (got_times[0] == last_take_time + 4 * CLK_PERIOD + CLK_PERIOD / 2) else begin
                $display("first output row came at %0t, not 4 cycles after the last beat",
                         got_times[0]);
                test_errors++;
            end
            for (int k = 1; k < `CONV_CHANS; k++) begin
                assert (got_times[k] == got_times[k - 1] + CLK_PERIOD) else begin
                    $display("channel %0d did not follow channel %0d on the next cycle",
                             k, k - 1);
                    test_errors++;
                end
            end
        end
    end
    got_rows.delete();
    got_chans.delete();
    got_times.delete();
    exp_rows.delete();
endtask

task automatic finish_test(input string name);
    if (test_errors == 0) begin
        tests_passed++;
        $display("test %s: ok", name);
    end else begin
        tests_failed++;
        $display("test %s: %0d errors", name, test_errors);
    end
    test_errors = 0;
endtask

//////////////////////////////////////////////////
// directed tests
//////////////////////////////////////////////////

task automatic idle_after_reset_test();
    repeat (20) begin
        @(negedge clk);
        assert (!out_valid) else begin
            $display("** Error: out_valid expected 0x0, got 0x%h", out_valid);
            test_errors++;
        end
    end
    finish_test("idle after reset");
endtask

task automatic single_tile_test();
    tile_param_t p;
    for (int ch = 0; ch < `CONV_CHANS; ch++) begin
        p[ch] = chan_param(3 * ch - 4, 1, 0);   // plain dot sum plus bias
    end
    tile_q.delete();
    add_beat('{1, 2, 3, 4}, '{1, 2, -1, 3});
    add_beat('{-2, 5, 0, 1}, '{2, -1, 1, 1});
    add_beat('{3, -3, 2, 2}, '{1, 1, 1, -2});
    send_tile(0, 1'b1, p);
    expect_tile(p);
    idle_cycles(1);
    check_outputs(1'b1);
    finish_test("single tile");
endtask

task automatic rounding_test();
    tile_param_t p;
    p[0] = chan_param(0, 1, 1);     // +-2.5 and +-3.5
    p[1] = chan_param(0, 2, 2);
    p[2] = chan_param(0, 1, 1);     // +-7.5
    p[3] = chan_param(1, 4, 3);
    tile_q.delete();
    add_beat('{5, -5, 7, -7}, '{1, 1, 3, 1});
    send_tile(0, 1'b1, p);
    expect_tile(p);
    idle_cycles(1);
    check_outputs(1'b0);
    finish_test("rounding");
endtask

task automatic saturation_test();
    tile_param_t p;
    p[0] = chan_param(0, 16'hffff, 4);
    p[1] = chan_param(-128, 16'h8000, 0);
    p[2] = chan_param(127, 16'h00ff, 2);
    p[3] = chan_param(0, 1, 3);     // stays in range
    tile_q.delete();
    add_beat('{127, -128, 127, -128}, '{127, 127, -128, 1});
    add_beat('{127, -128, 127, -128}, '{127, 127, -128, 1});
    send_tile(0, 1'b1, p);
    expect_tile(p);
    idle_cycles(1);
    check_outputs(1'b0);
    finish_test("saturation");
endtask

task automatic random_tiles_test();
    tile_param_t p;
    int nbeats;
    for (int t = 0; t < 10; t++) begin
        for (int ch = 0; ch < `CONV_CHANS; ch++) begin
            p[ch] = chan_param($random(seed), $random(seed), $unsigned($random(seed)) % 24);
        end
        nbeats = 4 + int'($unsigned($random(seed)) % 5);
        tile_q.delete();
        repeat (nbeats) add_random_beat();
        send_tile(2, 1'b1, p);      // new params ride on the first beat
        expect_tile(p);
        idle_cycles(int'($unsigned($random(seed)) % 3));
    end
    idle_cycles(1);
    check_outputs(1'b0);
    finish_test("random tiles");
endtask

task automatic gap_and_load_test();
    tile_param_t p_old;
    tile_param_t p_new;
    for (int ch = 0; ch < `CONV_CHANS; ch++) begin
        p_old[ch] = chan_param(ch, 3, 1);
        p_new[ch] = chan_param(-ch, 5 + ch, 2);
    end
    tile_q.delete();
    repeat (6) add_random_beat();
    tile_q[tile_q.size() - 1].last = 1'b1;
    load_params(p_old);
    foreach (tile_q[i]) begin
        if (i == 3) begin
            load_params(p_new);     // before the last beat, so it applies
        end
        idle_cycles(1 + i % 2);
        drive_cycle(1'b1, tile_q[i], 1'b0, '0);
    end
    expect_tile(p_new);
    send_tile(0, 1'b0, p_new);      // same beats, no gaps
    expect_tile(p_new);
    idle_cycles(1);
    check_outputs(1'b0);
    finish_test("gaps and mid tile load");
endtask

/* bench/tb_conv_core.sv */
`include "conv_macros.svh"

module tb_conv_core import conv_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 10;
    localparam int WAIT_LIMIT = 200;    // cycles per wait

    logic        clk;
    logic        reset;
    logic        pix_valid;
    beat_t       beat_in;
    logic        param_load;
    tile_param_t params_in;
    logic        out_valid;
    logic [1:0]  out_chan;
    q_row_t      out_row;

    q_row_t      got_rows[$];       // as the monitor saw them
    logic [1:0]  got_chans[$];
    time         got_times[$];
    q_row_t      exp_rows[$];       // model results in presentation order
    beat_t       tile_q[$];         // tile under construction
    time         last_take_time;    // edge that took the latest last beat
    integer      seed;
    int          test_errors;
    int          tests_passed;
    int          tests_failed;

    conv_core conv_core_i (
        .clk        (clk),
        .reset      (reset),
        .pix_valid  (pix_valid),
        .beat_in    (beat_in),
        .param_load (param_load),
        .params_in  (params_in),
        .out_valid  (out_valid),
        .out_chan   (out_chan),
        .out_row    (out_row)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // sample mid cycle, away from the driving edge
    always @(negedge clk) begin
        if (!reset && out_valid) begin
            got_rows.push_back(out_row);
            got_chans.push_back(out_chan);
            got_times.push_back($time);
        end
    end

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    // dot sum per column, then bias, tail, round half up, shift, clamp
    function automatic q_set_t model_tile(input tile_param_t p);
        q_set_t res;
        longint acc;
        longint val;
        byte    px;
        byte    wt;
        int     rank;
        for (int ch = 0; ch < `CONV_CHANS; ch++) begin
            rank = int'(p[ch].rank);
            for (int c = 0; c < `CONV_COLS; c++) begin
                acc = 0;
                foreach (tile_q[b]) begin
                    px = tile_q[b].pixels[c];
                    wt = tile_q[b].weights[ch];
                    acc += longint'(px) * longint'(wt);
                end
                px = p[ch].bias;
                val = (acc + longint'(px)) * longint'(p[ch].tail);
                if (rank > 0) begin
                    val += longint'(1) << (rank - 1);
                end
                val = val >>> rank;
                if (val > 127) begin
                    val = 127;
                end else if (val < -128) begin
                    val = -128;
                end
                res[ch][c] = val[7:0];
            end
        end
        return res;
    endfunction

    `include "conv_tests.svh"

    initial begin
        reset          = 1'b1;
        pix_valid      = 1'b0;
        beat_in        = '0;
        param_load     = 1'b0;
        params_in      = '0;
        seed           = 44;
        test_errors    = 0;
        tests_passed   = 0;
        tests_failed   = 0;
        last_take_time = 0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        idle_after_reset_test();
        single_tile_test();
        rounding_test();
        saturation_test();
        random_tiles_test();
        gap_and_load_test();

        $display("summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+source
+incdir+bench
source/conv_pkg.sv
source/beat_feeder.sv
source/channel_lane.sv
source/result_drain.sv
source/conv_core.sv
bench/tb_conv_core.sv

/* Makefile */
SRCS := $(shell grep -v '^+' sources.f) $(wildcard source/*.svh bench/*.svh)

.PHONY: run clean

run: obj_dir/Vtb_conv_core
	./obj_dir/Vtb_conv_core | tee sim.log
	grep -q '^TESTBENCH PASSED$$' sim.log

obj_dir/Vtb_conv_core: sources.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_conv_core \
		-f sources.f -o Vtb_conv_core

clean:
	rm -rf obj_dir sim.log
